/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mandel_tb
FILELIST = mandel.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)
FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* mandel.f */
verilog/mandel_fix_pkg.sv
verilog/mandel_regs_pkg.sv
verilog/mandel_ifs.sv
verilog/escape_iterator.sv
verilog/frame_scan.sv
verilog/mandel_host_port.sv
verilog/mandel_core.sv
tb/tb_clock.sv
tb/mandel_sva.sv
tb/mandel_tb.sv

/* tb/mandel_sva.sv */
`timescale 1ns/1ps

module mandel_sva (
	input logic        clk_i,
	input logic        reset_i,
	input logic        awvalid_i,
	input logic        wvalid_i,
	input logic        awready_i,
	input logic        bvalid_i,
	input logic        bready_i,
	input logic        rvalid_i,
	input logic        rready_i,
	input logic [31:0] rdata_i,
	input logic [1:0]  rresp_i
);

	// Failed assertions, summed into the testbench error count
	int unsigned fail_count = 0;

	// Write response waits for bready
	bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		bvalid_i && !bready_i |=> bvalid_i)
		else begin
			$error("bvalid fell before bready");
			fail_count++;
		end

	// Read data frozen while the master stalls
	rdata_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
		else begin
			$error("rvalid, rdata or rresp moved before rready");
			fail_count++;
		end

	// Address and data only ever taken together
	aw_with_w: assert property (@(posedge clk_i) disable iff (reset_i)
		awready_i |-> awvalid_i && wvalid_i)
		else begin
			$error("awready without both awvalid and wvalid");
			fail_count++;
		end

endmodule

bind mandel_core mandel_sva handshake_chk (
	.clk_i(clk), .reset_i(reset),
	.awvalid_i(awvalid_i), .wvalid_i(wvalid_i), .awready_i(awready_o),
	.bvalid_i(bvalid_o), .bready_i(bready_i),
	.rvalid_i(rvalid_o), .rready_i(rready_i), .rdata_i(rdata_o), .rresp_i(rresp_o)
);

/* tb/mandel_tb.sv */
`timescale 1ns/1ps

module mandel_tb;
	import mandel_fix_pkg::*;
	import mandel_regs_pkg::*;

	localparam int FRAME_W = 16;
	localparam int FRAME_H = 12;
	localparam logic [31:0] SEED = 32'h313f_eb1f;
	// One frame at iter_max 64 is at most 192 * (64 * 3 + 4) cycles, about 38k
	// Two frames plus polling and stalled pixel reads stay well below this
	localparam int MAX_CYCLES = 300000;
	localparam longint ONE = longint'(1) << FRAC_BITS;

	logic        clk;
	logic        reset;
	logic        awvalid;
	logic        awready;
	logic [11:0] awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [11:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] rng_state;

	tb_clock #(.PERIOD_NS(20)) clk_gen (.clk_o(clk));

	mandel_core #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) uut (
		.clk(clk), .reset(reset),
		.awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
		.wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
		.bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
		.arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
		.rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp)
	);

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Back into 27 bit two's complement
	function automatic longint wrap27(input longint v);
		logic signed [26:0] t;
		t = v[26:0];
		return longint'(t);
	endfunction

	// 4.23 product, fraction bits dropped by floor
	function automatic longint fx_mul(input longint a, input longint b);
		return wrap27((a * b) >>> FRAC_BITS);
	endfunction

	// Escape count of one point, then its colour band
	function automatic logic [7:0] expected_color(input longint cre, input longint cim,
		input longint iter_max);
		longint zr;
		longint zi;
		longint sr;
		longint si;
		longint cr;
		longint mag;
		longint n;
		logic   esc;
		zr = 0;
		zi = 0;
		n = 0;
		esc = 1'b0;
		while (!esc) begin
			sr = fx_mul(zr, zr);
			si = fx_mul(zi, zi);
			cr = fx_mul(zr, zi);
			mag = wrap27(sr + si);
			// Tests use z from before this step
			esc = (mag > 4 * ONE) || (mag < 0)
				|| (zr > 2 * ONE) || (zr < -2 * ONE)
				|| (zi > 2 * ONE) || (zi < -2 * ONE)
				|| (n == iter_max - 1);
			zr = wrap27(sr - si + cre);
			zi = wrap27(wrap27(2 * cr) + cim);
			n++;
		end
		if (n >= iter_max - 1) begin
			return 8'h00;
		end
		for (int k = 1; k <= 8; k++) begin
			if (n >= (iter_max >> k))
				return BAND_COLORS[k];
		end
		return BAND_COLORS[9];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, got);
		end
	endtask

	// Outputs are sampled on the falling edge, inputs change on the rising edge
	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		// Write response held for two cycles before bready
		repeat (2)
			@(negedge clk);
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	// Response held for stall cycles before rready
	task automatic axil_read(input logic [11:0] addr, input int stall,
		output logic [31:0] data, output logic [1:0] resp);
		int lat;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		lat = 1;
		@(negedge clk);
		while (!rvalid) begin
			lat++;
			@(negedge clk);
		end
		check_equal("read latency", 32'(lat), 32'd2);
		data = rdata;
		resp = rresp;
		repeat (stall) begin
			@(negedge clk);
			checks++;
			assert (rvalid && rdata === data && rresp === resp) else begin
				errors++;
				$display("Read response changed during an rready stall at %0t ns", $time);
			end
		end
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axil_write(addr, data, strb, resp);
		check_equal($sformatf("bresp_o at %h", addr), 32'(resp), 32'(exp_resp));
	endtask

	task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(addr, 0, data, resp);
		check_equal($sformatf("rdata_o at %h", addr), data, exp_data);
		check_equal($sformatf("rresp_o at %h", addr), 32'(resp), 32'(exp_resp));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic after_reset();
		@(negedge clk);
		check_equal("bvalid_o", 32'(bvalid), 32'd0);
		check_equal("rvalid_o", 32'(rvalid), 32'd0);
		read_expect(REG_STATUS, 32'd0, RESP_OKAY);
		read_expect(REG_ITER_MAX, 32'd64, RESP_OKAY);
	endtask

	task automatic register_readback();
		// Zoom keeps 5 bits, pan keeps 27
		write_expect(REG_ZOOM, 32'hFFFF_FFE3, 4'hF, RESP_OKAY);
		read_expect(REG_ZOOM, 32'h0000_0003, RESP_OKAY);
		write_expect(REG_PAN_X, 32'hA5A5_A5A5, 4'hF, RESP_OKAY);
		read_expect(REG_PAN_X, 32'h05A5_A5A5, RESP_OKAY);
		write_expect(REG_PAN_Y, 32'hFFFF_FFFF, 4'hF, RESP_OKAY);
		read_expect(REG_PAN_Y, 32'h07FF_FFFF, RESP_OKAY);
		write_expect(REG_ITER_MAX, 32'h1234_5678, 4'hF, RESP_OKAY);
		// Only byte 1 replaced
		write_expect(REG_ITER_MAX, 32'hAABB_CCDD, 4'b0010, RESP_OKAY);
		read_expect(REG_ITER_MAX, 32'h1234_CC78, RESP_OKAY);
		read_expect(REG_CTRL, 32'd0, RESP_OKAY);
		// Holes and the end of the pixel region
		write_expect(12'h020, 32'hDEAD_BEEF, 4'hF, RESP_SLVERR);
		read_expect(12'h020, 32'd0, RESP_SLVERR);
		write_expect(PIXEL_BASE, 32'h0000_00FF, 4'hF, RESP_SLVERR);
		read_expect(PIXEL_BASE + 12'(4 * FRAME_W * FRAME_H), 32'd0, RESP_SLVERR);
	endtask

	// Render one frame and compare every pixel, optionally poking CTRL mid frame
	task automatic full_frame(input int zoom, input longint pan_x, input longint pan_y,
		input int iter_max, input bit poke_busy);
		longint      step;
		longint      cre;
		longint      cim;
		logic [31:0] data;
		logic [1:0]  resp;
		logic [7:0]  color;
		int          stall;
		write_expect(REG_ZOOM, 32'(zoom), 4'hF, RESP_OKAY);
		write_expect(REG_PAN_X, 32'(pan_x), 4'hF, RESP_OKAY);
		write_expect(REG_PAN_Y, 32'(pan_y), 4'hF, RESP_OKAY);
		write_expect(REG_ITER_MAX, 32'(iter_max), 4'hF, RESP_OKAY);
		write_expect(REG_CTRL, 32'd1, 4'hF, RESP_OKAY);
		if (poke_busy) begin
			read_expect(REG_STATUS, 32'd2, RESP_OKAY);
			write_expect(REG_CTRL, 32'd1, 4'hF, RESP_OKAY);
		end
		data = '0;
		while (!data[0])
			axil_read(REG_STATUS, 0, data, resp);
		check_equal("STATUS when done", data, 32'd1);
		step = longint'(BASE_STEP) >>> zoom;
		for (int y = 0; y < FRAME_H; y++) begin
			for (int x = 0; x < FRAME_W; x++) begin
				cre = wrap27(wrap27(pan_x) + x * step);
				cim = wrap27(wrap27(pan_y) - y * step);
				color = expected_color(cre, cim, longint'(iter_max));
				rng_state = xorshift32(rng_state);
				stall = int'(rng_state[2:0]);
				axil_read(PIXEL_BASE + 12'(4 * (y * FRAME_W + x)), stall, data, resp);
				check_equal($sformatf("rdata_o pixel %0d,%0d", x, y), data, {24'd0, color});
				check_equal("rresp_o pixel", 32'(resp), 32'(RESP_OKAY));
			end
		end
	endtask

	initial begin
		longint pan_x;
		longint pan_y;
		rng_state = SEED;
		reset   = 1'b1;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		repeat (10) @(posedge clk);
		reset  <= 1'b0;

		after_reset();
		register_readback();

		// Seahorse valley, near the boundary so all bands show up
		rng_state = xorshift32(rng_state);
		pan_x = -(3 * ONE) / 4 + longint'(rng_state[17:0]);
		rng_state = xorshift32(rng_state);
		pan_y = ONE / 10 + longint'(rng_state[17:0]);
		full_frame(1, pan_x, pan_y, 64, 1'b0);

		// Deeper zoom on the period two bulb edge
		rng_state = xorshift32(rng_state);
		pan_x = -(5 * ONE) / 4 + longint'(rng_state[17:0]);
		rng_state = xorshift32(rng_state);
		pan_y = ONE / 50 + longint'(rng_state[17:0]);
		full_frame(3, pan_x, pan_y, 40, 1'b1);

		errors = errors + int'(uut.handshake_chk.fail_count);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

// Free running testbench clock
module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* verilog/escape_iterator.sv */
`timescale 1ns/1ps

module escape_iterator (
	input  logic                   clk_i,
	input  logic                   reset_i,
	escape_job_if.iterator         job,
	input  mandel_fix_pkg::count_t iter_max_i
);
	import mandel_fix_pkg::*;

	// One multiplier, three passes per iteration
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SQ_RE,
		ST_SQ_IM,
		ST_CROSS
	} state_t;

	state_t             state;
	logic               res_valid;
	fix_t               c_re;
	fix_t               c_im;
	fix_t               zr;
	fix_t               zi;
	fix_t               zr_sq;
	fix_t               zi_sq;
	count_t             count;
	fix_t               mul_a;
	fix_t               mul_b;
	logic signed [53:0] prod;
	fix_t               mul_out;
	fix_t               zr_next;
	fix_t               zi_next;
	fix_t               mag_sq;
	logic               escape;

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	// Operand select, cross product outside the squaring passes
	always_comb begin
		mul_a = zr;
		mul_b = zi;
		if (state == ST_SQ_RE) begin
			mul_b = zr;
		end else if (state == ST_SQ_IM) begin
			mul_a = zi;
		end
	end

	// Full product, back to 4.23 with the sign bit kept
	assign prod    = mul_a * mul_b;
	assign mul_out = {prod[53], prod[FRAC_BITS +: 26]};

	assign zr_next = zr_sq - zi_sq + c_re;
	assign zi_next = (mul_out <<< 1) + c_im;
	assign mag_sq  = zr_sq + zi_sq;

	// Negative magnitude means the sum wrapped
	assign escape = (mag_sq > ESC_MAG_LIMIT) || mag_sq[26]
		|| (zr > ESC_COORD_LIMIT) || (zr < -ESC_COORD_LIMIT)
		|| (zi > ESC_COORD_LIMIT) || (zi < -ESC_COORD_LIMIT)
		|| (count == iter_max_i - 1);

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state     <= ST_IDLE;
			res_valid <= 1'b0;
		end else begin
			if (res_valid && job.result_ready)
				res_valid <= 1'b0;
			case (state)
				ST_IDLE:  if (job.job_valid && job.job_ready) state <= ST_SQ_RE;
				ST_SQ_RE: state <= ST_SQ_IM;
				ST_SQ_IM: state <= ST_CROSS;
				ST_CROSS: begin
					// Count is bumped in this same cycle
					state     <= escape ? ST_IDLE : ST_SQ_RE;
					res_valid <= escape;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		case (state)
			ST_IDLE: begin
				if (job.job_valid && job.job_ready) begin
					c_re  <= job.c_re;
					c_im  <= job.c_im;
					zr    <= '0;
					zi    <= '0;
					count <= '0;
				end
			end
			ST_SQ_RE: zr_sq <= mul_out;
			ST_SQ_IM: zi_sq <= mul_out;
			ST_CROSS: begin
				zr    <= zr_next;
				zi    <= zi_next;
				count <= count + 1;
			end
		endcase
	end

	// Next job only after the previous count has been taken
	assign job.job_ready    = (state == ST_IDLE) && !res_valid;
	assign job.result_valid = res_valid;
	assign job.count        = count;

endmodule

/* verilog/frame_scan.sv */
`timescale 1ns/1ps

module frame_scan #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic       clk_i,
	input  logic       reset_i,
	frame_ctrl_if.scan ctrl,
	escape_job_if.scan job
);
	import mandel_fix_pkg::*;

	localparam int NUM_PIX = FRAME_W * FRAME_H;
	localparam int ADDR_W  = $clog2(NUM_PIX);
	localparam int X_W     = $clog2(FRAME_W);

	// Frame parameters held for the whole frame
	fix_t              step;
	fix_t              pan_x_q;
	count_t            iter_max_q;

	// Coordinate of the next job
	fix_t              cx;
	fix_t              cy;
	logic [X_W-1:0]    px;

	logic              busy;
	logic              done;
	logic              job_valid;
	logic              go;
	logic              res_take;
	logic [ADDR_W-1:0] wr_addr;
	color_t            band_color;

	assign go       = ctrl.start && !busy;
	assign res_take = job.result_valid && busy;

	////////////////////////////////////////////////////////////////////////////
	// Frame sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy      <= 1'b0;
			done      <= 1'b0;
			job_valid <= 1'b0;
		end else if (go) begin
			busy      <= 1'b1;
			done      <= 1'b0;
			job_valid <= 1'b1;
		end else begin
			if (job_valid && job.job_ready)
				job_valid <= 1'b0;
			// Last write ends the frame, otherwise send the next pixel
			if (res_take) begin
				if (wr_addr == ADDR_W'(NUM_PIX - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					job_valid <= 1'b1;
				end
			end
		end
	end

	// Coordinates step ahead as soon as a job is handed over
	always_ff @(posedge clk_i) begin
		if (go) begin
			step       <= BASE_STEP >>> ctrl.zoom;
			pan_x_q    <= ctrl.pan_x;
			iter_max_q <= ctrl.iter_max;
			cx         <= ctrl.pan_x;
			cy         <= ctrl.pan_y;
			px         <= '0;
			wr_addr    <= '0;
		end else begin
			if (job_valid && job.job_ready) begin
				if (px == X_W'(FRAME_W - 1)) begin
					// New row, y goes down the screen
					px <= '0;
					cx <= pan_x_q;
					cy <= cy - step;
				end else begin
					px <= px + 1'b1;
					cx <= cx + step;
				end
			end
			if (res_take)
				wr_addr <= wr_addr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Colour bands
	////////////////////////////////////////////////////////////////////////////

	// Smallest k wins, so the loop runs downwards
	always_comb begin
		band_color = BAND_COLORS[9];
		for (int k = 8; k >= 1; k--) begin
			if (job.count >= (iter_max_q >> k))
				band_color = BAND_COLORS[k];
		end
		if (job.count >= iter_max_q - 1)
			band_color = '0;
	end

	assign job.job_valid    = job_valid;
	assign job.c_re         = cx;
	assign job.c_im         = cy;
	assign job.result_ready = busy;
	assign ctrl.pix_we      = res_take;
	assign ctrl.pix_addr    = wr_addr;
	assign ctrl.pix_color   = band_color;
	assign ctrl.busy        = busy;
	assign ctrl.done        = done;

endmodule

/* verilog/mandel_core.sv */
`timescale 1ns/1ps

module mandel_core #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   awvalid_i,
	output logic                                   awready_o,
	input  logic [mandel_regs_pkg::AXI_ADDR_W-1:0]   awaddr_i,
	input  logic                                   wvalid_i,
	output logic                                   wready_o,
	input  logic [mandel_regs_pkg::AXI_DATA_W-1:0]   wdata_i,
	input  logic [mandel_regs_pkg::AXI_DATA_W/8-1:0] wstrb_i,
	output logic                                   bvalid_o,
	input  logic                                   bready_i,
	output logic [1:0]                             bresp_o,
	input  logic                                   arvalid_i,
	output logic                                   arready_o,
	input  logic [mandel_regs_pkg::AXI_ADDR_W-1:0]   araddr_i,
	output logic                                   rvalid_o,
	input  logic                                   rready_i,
	output logic [mandel_regs_pkg::AXI_DATA_W-1:0]   rdata_o,
	output logic [1:0]                             rresp_o
);

	// Host side registers and frame buffer, scan, and one iterator
	frame_ctrl_if #(.ADDR_W($clog2(FRAME_W * FRAME_H))) ctrl_if ();
	escape_job_if job_if ();

	mandel_host_port #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_host (
		.clk_i(clk), .reset_i(reset),
		.awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i, .wstrb_i,
		.bvalid_o, .bready_i, .bresp_o,
		.arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o,
		.ctrl(ctrl_if.host)
	);

	frame_scan #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_scan (
		.clk_i(clk), .reset_i(reset), .ctrl(ctrl_if.scan), .job(job_if.scan)
	);

	escape_iterator u_iter (
		.clk_i(clk), .reset_i(reset), .job(job_if.iterator), .iter_max_i(ctrl_if.iter_max)
	);

endmodule

/* verilog/mandel_fix_pkg.sv */
package mandel_fix_pkg;

	// Signed 4.23 fixed point
	localparam int FRAC_BITS = 23;
	typedef logic signed [26:0] fix_t;

	// Iteration count, zoom level, RGB332 colour
	typedef logic [31:0] count_t;
	typedef logic [4:0]  zoom_t;
	typedef logic [7:0]  color_t;

	// Pixel step at zoom 0, about 0.00464
	localparam fix_t BASE_STEP = 27'sd39000;

	// Escape thresholds, 4.0 on |z|^2 and 2.0 on each coordinate
	localparam fix_t ESC_MAG_LIMIT   = fix_t'(4 << FRAC_BITS);
	localparam fix_t ESC_COORD_LIMIT = fix_t'(2 << FRAC_BITS);

	// Band colours, band 1 closest to the set, band 9 for fast escapes
	localparam color_t BAND_COLORS [1:9] = '{
		8'b011_001_00,
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10,
		8'b010_100_10,
		8'b010_100_10
	};

endpackage

/* verilog/mandel_host_port.sv */
`timescale 1ns/1ps

module mandel_host_port #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                                 clk_i,
	input  logic                                 reset_i,
	input  logic                                 awvalid_i,
	output logic                                 awready_o,
	input  logic [mandel_regs_pkg::AXI_ADDR_W-1:0] awaddr_i,
	input  logic                                 wvalid_i,
	output logic                                 wready_o,
	input  logic [mandel_regs_pkg::AXI_DATA_W-1:0] wdata_i,
	input  logic [mandel_regs_pkg::AXI_DATA_W/8-1:0] wstrb_i,
	output logic                                 bvalid_o,
	input  logic                                 bready_i,
	output logic [1:0]                           bresp_o,
	input  logic                                 arvalid_i,
	output logic                                 arready_o,
	input  logic [mandel_regs_pkg::AXI_ADDR_W-1:0] araddr_i,
	output logic                                 rvalid_o,
	input  logic                                 rready_i,
	output logic [mandel_regs_pkg::AXI_DATA_W-1:0] rdata_o,
	output logic [1:0]                           rresp_o,
	frame_ctrl_if.host                           ctrl
);
	import mandel_fix_pkg::*;
	import mandel_regs_pkg::*;

	localparam int NUM_PIX = FRAME_W * FRAME_H;
	localparam int ADDR_W  = $clog2(NUM_PIX);

	logic                  wr_go;
	logic                  ar_go;
	logic                  start_q;
	zoom_t                 zoom_q;
	fix_t                  pan_x_q;
	fix_t                  pan_y_q;
	count_t                iter_max_q;
	logic [AXI_ADDR_W-1:0] pix_off;
	logic                  pix_hit;
	logic                  rd_stage;
	logic [AXI_ADDR_W-1:0] rd_addr;
	logic                  rd_pix;
	color_t                pix_q;
	logic [AXI_DATA_W-1:0] rd_word;
	logic                  rd_ok;
	color_t                fb [NUM_PIX];

	// Byte lanes of a write merged into the old value
	function automatic logic [AXI_DATA_W-1:0] merge_bytes(
		input logic [AXI_DATA_W-1:0]   old_v,
		input logic [AXI_DATA_W-1:0]   new_v,
		input logic [AXI_DATA_W/8-1:0] strb
	);
		logic [AXI_DATA_W-1:0] res;
		res = old_v;
		for (int b = 0; b < AXI_DATA_W / 8; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_v[8*b +: 8];
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////////////////////

	// Address and data taken together, one response outstanding
	assign wr_go     = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = wr_go;
	assign wready_o  = wr_go;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			bvalid_o   <= 1'b0;
			start_q    <= 1'b0;
			zoom_q     <= '0;
			pan_x_q    <= '0;
			pan_y_q    <= '0;
			iter_max_q <= count_t'(64);
		end else begin
			start_q <= 1'b0;
			if (bvalid_o && bready_i)
				bvalid_o <= 1'b0;
			if (wr_go) begin
				bvalid_o <= 1'b1;
				case (awaddr_i)
					// Start request dropped while a frame runs
					REG_CTRL: start_q <= wdata_i[0] && wstrb_i[0] && !ctrl.busy;
					REG_ZOOM:
						zoom_q <= zoom_t'(merge_bytes(AXI_DATA_W'(zoom_q), wdata_i, wstrb_i));
					REG_PAN_X:
						pan_x_q <= fix_t'(merge_bytes(AXI_DATA_W'(pan_x_q), wdata_i, wstrb_i));
					REG_PAN_Y:
						pan_y_q <= fix_t'(merge_bytes(AXI_DATA_W'(pan_y_q), wdata_i, wstrb_i));
					REG_ITER_MAX: iter_max_q <= merge_bytes(iter_max_q, wdata_i, wstrb_i);
					default: ;
				endcase
			end
		end
	end

	// STATUS takes writes silently, pixel words are read only
	always_ff @(posedge clk_i) begin
		if (wr_go)
			bresp_o <= (awaddr_i inside {REG_CTRL, REG_STATUS, REG_ZOOM, REG_PAN_X,
				REG_PAN_Y, REG_ITER_MAX}) ? RESP_OKAY : RESP_SLVERR;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read channel and frame buffer
	////////////////////////////////////////////////////////////////////////////

	assign ar_go     = arvalid_i && !rd_stage && !rvalid_o;
	assign arready_o = ar_go;
	assign pix_off   = araddr_i - PIXEL_BASE;
	assign pix_hit   = (araddr_i >= PIXEL_BASE) && (pix_off < AXI_ADDR_W'(4 * NUM_PIX));

	// Two cycle read, memory then output register
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rd_stage <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			rd_stage <= ar_go;
			if (rd_stage)
				rvalid_o <= 1'b1;
			else if (rvalid_o && rready_i)
				rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ctrl.pix_we)
			fb[ctrl.pix_addr] <= ctrl.pix_color;
		if (ar_go && pix_hit)
			pix_q <= fb[pix_off[ADDR_W+1:2]];
		if (ar_go) begin
			rd_addr <= araddr_i;
			rd_pix  <= pix_hit;
		end
		if (rd_stage) begin
			rdata_o <= rd_word;
			rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_comb begin
		rd_word = '0;
		rd_ok   = 1'b1;
		case (rd_addr)
			REG_CTRL:     rd_word = '0;
			REG_STATUS:   rd_word = {30'd0, ctrl.busy, ctrl.done};
			REG_ZOOM:     rd_word = {27'd0, zoom_q};
			REG_PAN_X:    rd_word = {5'd0, pan_x_q};
			REG_PAN_Y:    rd_word = {5'd0, pan_y_q};
			REG_ITER_MAX: rd_word = iter_max_q;
			default: begin
				rd_ok = rd_pix;
				if (rd_pix)
					rd_word = {24'd0, pix_q};
			end
		endcase
	end

	assign ctrl.start    = start_q;
	assign ctrl.zoom     = zoom_q;
	assign ctrl.pan_x    = pan_x_q;
	assign ctrl.pan_y    = pan_y_q;
	assign ctrl.iter_max = iter_max_q;

endmodule

/* verilog/mandel_ifs.sv */
`timescale 1ns/1ps

// One pixel job from the scan to the iterator, and its escape count back
interface escape_job_if;
	import mandel_fix_pkg::*;

	logic   job_valid;
	logic   job_ready;
	fix_t   c_re;
	fix_t   c_im;
	logic   result_valid;
	logic   result_ready;
	count_t count;

	modport scan (output job_valid, c_re, c_im, result_ready,
		input job_ready, result_valid, count);
	modport iterator (input job_valid, c_re, c_im, result_ready,
		output job_ready, result_valid, count);
endinterface

// Frame parameters down to the scan, pixel writes and status back up
interface frame_ctrl_if #(
	parameter int ADDR_W = 8
);
	import mandel_fix_pkg::*;

	logic              start;
	zoom_t             zoom;
	fix_t              pan_x;
	fix_t              pan_y;
	count_t            iter_max;
	logic              pix_we;
	logic [ADDR_W-1:0] pix_addr;
	color_t            pix_color;
	logic              busy;
	logic              done;

	modport host (output start, zoom, pan_x, pan_y, iter_max,
		input pix_we, pix_addr, pix_color, busy, done);
	modport scan (input start, zoom, pan_x, pan_y, iter_max,
		output pix_we, pix_addr, pix_color, busy, done);
endinterface

/* verilog/mandel_regs_pkg.sv */
package mandel_regs_pkg;

	// AXI4-Lite bus widths
	localparam int AXI_ADDR_W = 12;
	localparam int AXI_DATA_W = 32;

	// Register map
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS   = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] REG_ZOOM     = 12'h008;
	localparam logic [AXI_ADDR_W-1:0] REG_PAN_X    = 12'h00C;
	localparam logic [AXI_ADDR_W-1:0] REG_PAN_Y    = 12'h010;
	localparam logic [AXI_ADDR_W-1:0] REG_ITER_MAX = 12'h014;

	// Pixel words start here, one word per pixel in row-major order
	localparam logic [AXI_ADDR_W-1:0] PIXEL_BASE   = 12'h400;

	// Response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
